//--- flist.f
+incdir+include
design/u2_core_pkg.sv
design/misc_ctrl_regs.sv
design/vita_time_counter.sv
design/readback_mux.sv
design/u2_core_top.sv
verif/u2_core_tb.sv

//--- Makefile
# Verilator build and run for the control slice testbench

SRCS := $(filter-out +%,$(shell cat flist.f)) include/u2_core_config.svh

.PHONY: run clean

obj_dir/Vu2_core_tb: flist.f $(SRCS)
	verilator --binary --timing -sv -f flist.f --top-module u2_core_tb -o Vu2_core_tb

run: obj_dir/Vu2_core_tb
	./obj_dir/Vu2_core_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- verif/u2_core_tb.sv
/* Testbench for the control slice top level
   Register, LED, VITA time and readback models with per-cycle compare */

`timescale 1ns/100ps
`include "u2_core_config.svh"

module u2_core_tb import u2_core_pkg::*; ();

   localparam int          TPS         = 50;
   localparam logic [31:0] TICK_LAST   = 32'(TPS - 1);
   localparam int          RST_CYCLES  = 16;
   localparam int          MISC_WRITES = 400;
   localparam int          COUNT_RUN   = 150;
   localparam int          ARM_WAIT    = 20;
   localparam int          RB_READS    = 16;
   // Each phase takes at most a few cycles per step, plus slack for the PPS sync
   localparam int MAX_CYCLES = 4 * (RST_CYCLES + MISC_WRITES + COUNT_RUN + ARM_WAIT
                                    + 3 * RB_READS) + 400;
   localparam logic [7:0]  A_MISC = 8'(`U2_SR_MISC);
   localparam logic [7:0]  A_TIME = 8'(`U2_SR_TIME64);

   logic        dsp_clk;
   logic        por_rst;
   set_bus_t    set_bus;
   logic        pps_i, run_tx_i, run_rx0_i, run_rx1_i;
   logic        clk_status_i, serdes_link_up_i, sim_mode_i;
   logic [3:0]  clock_divider_i;
   logic [31:0] status_i;
   logic        rb_stb_i;
   rb_word_e    rb_addr_i;
   misc_ctrl_t  ctrl_o;
   logic [7:0]  leds_o;
   vita_time_t  vita_time_o;
   logic        pps_int_o;
   logic [31:0] rb_data_o;
   logic        rb_ack_o;

   // Model state
   logic [4:0]  m_clk;
   logic [3:0]  m_ser, m_adc;
   logic        m_phy, m_run_rx_q, m_arm, m_ack;
   logic [7:0]  m_led_sw, m_led_src;
   vita_time_t  m_time, m_pend, m_pps, pps_time_seen;
   logic [31:0] m_rb_data;
   int          pps_pulses = 0;
   int          cycles = 0;
   int          seed = 32'hb04b;

   u2_core_top #(.TICKS_PER_SEC(TPS)) u_dut (
      .dsp_clk (dsp_clk), .por_rst (por_rst), .set_bus_i (set_bus), .pps_i (pps_i),
      .run_tx_i (run_tx_i), .run_rx0_i (run_rx0_i), .run_rx1_i (run_rx1_i),
      .clk_status_i (clk_status_i), .serdes_link_up_i (serdes_link_up_i),
      .sim_mode_i (sim_mode_i), .clock_divider_i (clock_divider_i), .status_i (status_i),
      .rb_stb_i (rb_stb_i), .rb_addr_i (rb_addr_i), .ctrl_o (ctrl_o), .leds_o (leds_o),
      .vita_time_o (vita_time_o), .pps_int_o (pps_int_o),
      .rb_data_o (rb_data_o), .rb_ack_o (rb_ack_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   //////////////////////////////
   // Reference functions
   //////////////////////////////

   function automatic misc_ctrl_t expected_ctrl(input logic [4:0] clk, input logic [3:0] ser,
                                                input logic [3:0] adc, input logic phy);
      misc_ctrl_t c;
      c.clock_ready = clk[4];
      c.clk_en      = clk[3:2];
      c.clk_sel     = clk[1:0];
      c.ser_enable  = ser[3];
      c.ser_prbsen  = ser[2];
      c.ser_loopen  = ser[1];
      c.ser_rx_en   = ser[0];
      c.adc_oe_a    = adc[3];
      c.adc_on_a    = adc[2];
      c.adc_oe_b    = adc[1];
      c.adc_on_b    = adc[0];
      c.phy_resetn  = ~phy;   // Register bit holds the PHY in reset
      return c;
   endfunction

   function automatic logic [7:0] expected_leds(input logic [7:0] src, input logic [7:0] sw,
                                                input logic tx, input logic rxq,
                                                input logic cs, input logic link);
      logic [7:0] hw;
      logic [7:0] leds;
      hw = {3'b000, tx, rxq, cs, link, 1'b0};
      for (int i = 0; i < 8; i++) begin
         leds[i] = src[i] ? hw[i] : sw[i];
      end
      return leds;
   endfunction

   function automatic vita_time_t advance_time(input vita_time_t t);
      vita_time_t n;
      n = t;
      if (t.ticks == TICK_LAST) begin
         n.ticks = 32'd0;
         n.secs  = t.secs + 32'd1;
      end else begin
         n.ticks = t.ticks + 32'd1;
      end
      return n;
   endfunction

   function automatic logic [31:0] expected_word(input rb_word_e idx, input logic [31:0] st,
                                                 input logic sim, input logic [3:0] div,
                                                 input vita_time_t t, input vita_time_t tp);
      case (idx)
         RB_STATUS:  return st;
         RB_SIM:     return {sim, 27'd0, div};
         RB_TIME_HI: return t.secs;
         RB_TIME_LO: return t.ticks;
         RB_COMPAT:  return 32'(`U2_COMPAT_NUM);
         RB_PPS_HI:  return tp.secs;
         RB_PPS_LO:  return tp.ticks;
         default:    return 32'd0;   // IRQ and unused words
      endcase
   endfunction

   // Misc offsets 0..9, so 5, 6, 7 and 9 hit unused slots
   function automatic logic [7:0] pick_misc_addr(input logic [31:0] r);
      logic [3:0] off;
      off = (r[3:0] > 4'd9) ? r[3:0] - 4'd6 : r[3:0];
      return A_MISC + {4'd0, off};
   endfunction

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_ctrl(input string name, input misc_ctrl_t got, input misc_ctrl_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "control line mismatch");
      end
   endtask

   task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "time mismatch");
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "word mismatch");
      end
   endtask

   //////////////////////////////
   // Model and compare
   //////////////////////////////

   // Follows the DUT edge by edge, reading inputs before they change
   always @(posedge dsp_clk) begin
      if (set_bus.stb && set_bus.addr == A_TIME + 8'(TIME_SECS)) m_pend.secs <= set_bus.data;
      if (set_bus.stb && set_bus.addr == A_TIME + 8'(TIME_TICKS)) m_pend.ticks <= set_bus.data;
      if (por_rst) begin
         m_clk <= '0;
         m_ser <= '0;
         m_adc <= '0;
         m_phy <= 1'b0;
         m_led_sw <= '0;
         m_led_src <= `U2_LED_SRC_RESET;
         m_run_rx_q <= 1'b0;
         m_time <= '0;
         m_pps <= '0;
         m_arm <= 1'b0;
         m_ack <= 1'b0;
      end else begin
         m_run_rx_q <= run_rx0_i | run_rx1_i;
         if (set_bus.stb) begin
            case (set_bus.addr)
               A_MISC + 8'(MISC_CLK):     m_clk     <= set_bus.data[4:0];
               A_MISC + 8'(MISC_SER):     m_ser     <= set_bus.data[3:0];
               A_MISC + 8'(MISC_ADC):     m_adc     <= set_bus.data[3:0];
               A_MISC + 8'(MISC_LED_SW):  m_led_sw  <= set_bus.data[7:0];
               A_MISC + 8'(MISC_PHY):     m_phy     <= set_bus.data[0];
               A_MISC + 8'(MISC_LED_SRC): m_led_src <= set_bus.data[7:0];
               default: ;
            endcase
         end
         if (set_bus.stb && set_bus.addr == A_TIME + 8'(TIME_IMM)) begin
            m_arm  <= set_bus.data[0];
            m_time <= set_bus.data[0] ? advance_time(m_time) : m_pend;
         end else if (m_arm && pps_int_o) begin   // Marker cycle loads the pending time
            m_arm  <= 1'b0;
            m_time <= m_pend;
         end else begin
            m_time <= advance_time(m_time);
         end
         if (pps_int_o) m_pps <= m_time;
         if (rb_stb_i) begin
            m_rb_data <= expected_word(rb_addr_i, status_i, sim_mode_i, clock_divider_i,
                                       m_time, m_pps);
         end
         m_ack <= rb_stb_i;
      end
   end

   always @(negedge dsp_clk) begin
      if (!por_rst) begin
         check_ctrl("ctrl_o", ctrl_o, expected_ctrl(m_clk, m_ser, m_adc, m_phy));
         check_word("leds_o", 32'(leds_o), 32'(expected_leds(m_led_src, m_led_sw, run_tx_i,
                    m_run_rx_q, clk_status_i, serdes_link_up_i)));
         check_time("vita_time_o", vita_time_o, m_time);
         check_word("rb_ack_o", 32'(rb_ack_o), 32'(m_ack));
         if (m_ack) check_word("rb_data_o", rb_data_o, m_rb_data);
         if (pps_int_o) begin
            pps_pulses    = pps_pulses + 1;
            pps_time_seen = vita_time_o;
         end
      end
   end

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      set_bus <= {1'b1, addr, data};
   endtask

   task automatic idle_bus();
      @(posedge dsp_clk);
      set_bus <= {1'b0, 8'd0, 32'd0};
   endtask

   // Returns the word and the time as it stood in the strobe cycle
   task automatic read_word(input rb_word_e idx, output logic [31:0] data,
                            output vita_time_t stb_time);
      @(posedge dsp_clk);
      rb_stb_i  <= 1'b1;
      rb_addr_i <= idx;
      @(negedge dsp_clk);
      stb_time = vita_time_o;
      @(posedge dsp_clk);
      rb_stb_i <= 1'b0;
      @(negedge dsp_clk);
      check_word("rb_ack_o", 32'(rb_ack_o), 32'd1);
      data = rb_data_o;
   endtask

   initial begin
      logic [31:0] r, d, word;
      vita_time_t  t_pend, tm;
      rb_word_e    idx;
      rb_word_e    fixed_idx [4] = '{RB_STATUS, RB_SIM, RB_COMPAT, RB_IRQ};
      por_rst = 1'b1;
      set_bus = '0;
      pps_i = 1'b0;
      run_tx_i = 1'b1;
      run_rx0_i = 1'b1;
      run_rx1_i = 1'b0;
      clk_status_i = 1'b1;
      serdes_link_up_i = 1'b1;
      sim_mode_i = 1'b0;
      clock_divider_i = 4'd0;
      status_i = 32'd0;
      rb_stb_i = 1'b0;
      rb_addr_i = RB_STATUS;
      repeat (RST_CYCLES) @(posedge dsp_clk);
      por_rst <= 1'b0;

      // Reset values, hardware LEDs through the reset source mask
      @(negedge dsp_clk);
      check_ctrl("ctrl_o", ctrl_o, expected_ctrl(5'd0, 4'd0, 4'd0, 1'b0));
      check_word("leds_o", 32'(leds_o), 32'(expected_leds(`U2_LED_SRC_RESET, 8'd0,
                 1'b1, 1'b0, 1'b1, 1'b1)));

      for (int i = 0; i < MISC_WRITES; i++) begin
         r = $random(seed);
         d = $random(seed);
         @(posedge dsp_clk);
         set_bus          <= {r[8], pick_misc_addr(r), d};
         run_tx_i         <= r[9];
         run_rx0_i        <= r[10];
         run_rx1_i        <= r[11];
         clk_status_i     <= r[12];
         serdes_link_up_i <= r[13];
      end
      idle_bus();

      // Set now, starting close to a second boundary
      t_pend.secs  = $random(seed);
      t_pend.ticks = 32'(TPS - 5);
      write_setting(A_TIME + 8'(TIME_SECS), t_pend.secs);
      write_setting(A_TIME + 8'(TIME_TICKS), t_pend.ticks);
      write_setting(A_TIME + 8'(TIME_IMM), 32'd0);
      idle_bus();
      @(negedge dsp_clk);
      check_time("vita_time_o", vita_time_o, t_pend);
      while (vita_time_o.ticks != 32'd0) @(negedge dsp_clk);
      check_word("vita_time_o.secs", vita_time_o.secs, t_pend.secs + 32'd1);
      repeat (COUNT_RUN) @(posedge dsp_clk);

      // Armed load waits for the PPS marker
      t_pend.secs  = $random(seed);
      t_pend.ticks = 32'd7;
      write_setting(A_TIME + 8'(TIME_SECS), t_pend.secs);
      write_setting(A_TIME + 8'(TIME_TICKS), t_pend.ticks);
      write_setting(A_TIME + 8'(TIME_IMM), 32'd1);
      idle_bus();
      repeat (ARM_WAIT) @(posedge dsp_clk);
      pps_i <= 1'b1;
      while (pps_pulses == 0) @(posedge dsp_clk);
      pps_i <= 1'b0;
      @(negedge dsp_clk);
      check_time("vita_time_o", vita_time_o, t_pend);

      read_word(RB_PPS_HI, word, tm);
      check_word("rb_data_o", word, pps_time_seen.secs);
      read_word(RB_PPS_LO, word, tm);
      check_word("rb_data_o", word, pps_time_seen.ticks);
      read_word(RB_TIME_HI, word, tm);
      check_word("rb_data_o", word, tm.secs);
      read_word(RB_TIME_LO, word, tm);
      check_word("rb_data_o", word, tm.ticks);

      for (int i = 0; i < 12; i++) begin
         idx = (i < 8) ? rb_word_e'(4'(i)) : fixed_idx[i - 8];
         r = $random(seed);
         @(posedge dsp_clk);
         status_i        <= r;
         sim_mode_i      <= r[31];
         clock_divider_i <= r[3:0];
         read_word(idx, word, tm);
         check_word("rb_data_o", word, expected_word(idx, status_i, sim_mode_i,
                    clock_divider_i, tm, pps_time_seen));
      end

      repeat (4) @(posedge dsp_clk);
      if (pps_pulses != 1) begin
         $display("Expected one PPS marker pulse but saw %0d", pps_pulses);
         $display("STATUS: FAIL");
         $fatal(1, "wrong PPS pulse count");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

//--- design/u2_core_top.sv
/* Top of the dsp_clk control slice
   Board control registers, VITA time counter and readback mux */

`timescale 1ns/100ps
`include "u2_core_config.svh"

module u2_core_top import u2_core_pkg::*; #(
   parameter int unsigned TICKS_PER_SEC = `U2_TICKS_PER_SEC
) (
   input  logic        dsp_clk,
   input  logic        por_rst,

   // Settings writes
   input  set_bus_t    set_bus_i,

   // Status inputs
   input  logic        pps_i,
   input  logic        run_tx_i,
   input  logic        run_rx0_i,
   input  logic        run_rx1_i,
   input  logic        clk_status_i,
   input  logic        serdes_link_up_i,
   input  logic        sim_mode_i,
   input  logic [3:0]  clock_divider_i,
   input  logic [31:0] status_i,

   // Readback request
   input  logic        rb_stb_i,
   input  rb_word_e    rb_addr_i,

   output misc_ctrl_t  ctrl_o,
   output logic [7:0]  leds_o,
   output vita_time_t  vita_time_o,
   output logic        pps_int_o,
   output logic [31:0] rb_data_o,
   output logic        rb_ack_o
);

   vita_time_t vita_time_pps;   // Time latched at the last PPS

   //////////////////////////////
   // Board control
   //////////////////////////////

   misc_ctrl_regs u_misc_regs (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_bus_i        (set_bus_i),
      .run_tx_i         (run_tx_i),
      .run_rx0_i        (run_rx0_i),
      .run_rx1_i        (run_rx1_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .ctrl_o           (ctrl_o),
      .leds_o           (leds_o)
   );

   //////////////////////////////
   // VITA time
   //////////////////////////////

   vita_time_counter #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) u_vita_time (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_bus_i  (set_bus_i),
      .pps_i      (pps_i),
      .time_o     (vita_time_o),
      .time_pps_o (vita_time_pps),
      .pps_int_o  (pps_int_o)
   );

   //////////////////////////////
   // Readback
   //////////////////////////////

   readback_mux u_readback (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .rb_stb_i        (rb_stb_i),
      .rb_addr_i       (rb_addr_i),
      .status_i        (status_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .time_i          (vita_time_o),
      .time_pps_i      (vita_time_pps),
      .rb_data_o       (rb_data_o),
      .rb_ack_o        (rb_ack_o)
   );

endmodule

//--- design/readback_mux.sv
/* Registered readback of status words by index */

`timescale 1ns/100ps
`include "u2_core_config.svh"

module readback_mux import u2_core_pkg::*; (
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        rb_stb_i,
   input  rb_word_e    rb_addr_i,
   input  logic [31:0] status_i,
   input  logic        sim_mode_i,
   input  logic [3:0]  clock_divider_i,
   input  vita_time_t  time_i,
   input  vita_time_t  time_pps_i,
   output logic [31:0] rb_data_o,
   output logic        rb_ack_o
);

   logic [31:0] words [`U2_RB_WORDS];

   // Words 0 to 7 are unused
   always_comb begin
      for (int i = 0; i < `U2_RB_WORDS; i++) begin
         words[i] = '0;
      end
      words[RB_STATUS]  = status_i;
      words[RB_SIM]     = {sim_mode_i, 27'd0, clock_divider_i};
      words[RB_TIME_HI] = time_i.secs;
      words[RB_TIME_LO] = time_i.ticks;
      words[RB_COMPAT]  = 32'(`U2_COMPAT_NUM);
      words[RB_IRQ]     = '0;          // No interrupt sources in this slice
      words[RB_PPS_HI]  = time_pps_i.secs;
      words[RB_PPS_LO]  = time_pps_i.ticks;
   end

   // Data captured in the strobe cycle
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= words[rb_addr_i];
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;   // Single cycle, never stalls
      end
   end

endmodule

//--- design/vita_time_counter.sv
/* 64-bit VITA time counter in seconds and ticks
   Immediate or PPS-aligned set, PPS synchronizer and PPS time latch */

`timescale 1ns/100ps
`include "u2_core_config.svh"

module vita_time_counter import u2_core_pkg::*; #(
   parameter int unsigned TICKS_PER_SEC = `U2_TICKS_PER_SEC
) (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_bus_i,
   input  logic       pps_i,
   output vita_time_t time_o,
   output vita_time_t time_pps_o,
   output logic       pps_int_o
);

   localparam logic [7:0]  ADDR_SECS  = 8'(`U2_SR_TIME64 + TIME_SECS);
   localparam logic [7:0]  ADDR_TICKS = 8'(`U2_SR_TIME64 + TIME_TICKS);
   localparam logic [7:0]  ADDR_IMM   = 8'(`U2_SR_TIME64 + TIME_IMM);
   localparam logic [31:0] TICK_LAST  = 32'(TICKS_PER_SEC - 1);

   vita_time_t     pend_time;    // Value waiting for the next load
   vita_time_t     time_next;
   time_set_mode_e arm_mode;     // TIME_SET_AT_PPS while a PPS load is pending
   logic           imm_wr;
   logic           load;
   logic           pps_s1;
   logic           pps_s2;
   logic           pps_s3;
   logic           pps_edge;

   //////////////////////////////
   // Settings decode
   //////////////////////////////

   assign imm_wr = set_bus_i.stb && (set_bus_i.addr == ADDR_IMM);

   always_ff @(posedge dsp_clk) begin
      if (set_bus_i.stb && set_bus_i.addr == ADDR_SECS) begin
         pend_time.secs <= set_bus_i.data;
      end
      if (set_bus_i.stb && set_bus_i.addr == ADDR_TICKS) begin
         pend_time.ticks <= set_bus_i.data;
      end
   end

   //////////////////////////////
   // PPS edge detect
   //////////////////////////////

   // Two sync flops, one history flop, then a registered rising edge
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_s1   <= 1'b0;
         pps_s2   <= 1'b0;
         pps_s3   <= 1'b0;
         pps_edge <= 1'b0;
      end else begin
         pps_s1   <= pps_i;
         pps_s2   <= pps_s1;
         pps_s3   <= pps_s2;
         pps_edge <= pps_s2 & ~pps_s3;
      end
   end

   assign pps_int_o = pps_edge;

   //////////////////////////////
   // Time counter
   //////////////////////////////

   always_comb begin
      time_next = time_o;
      if (time_o.ticks == TICK_LAST) begin   // End of second
         time_next.ticks = '0;
         time_next.secs  = time_o.secs + 32'd1;
      end else begin
         time_next.ticks = time_o.ticks + 32'd1;
      end
   end

   // Set now on the write itself, or on the first PPS edge once armed
   assign load = (imm_wr && !set_bus_i.data[0]) ||
                 (arm_mode == TIME_SET_AT_PPS && pps_edge);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_o   <= '0;
         arm_mode <= TIME_SET_NOW;
      end else begin
         if (load) begin
            time_o <= pend_time;
         end else begin
            time_o <= time_next;
         end

         if (imm_wr) begin
            arm_mode <= time_set_mode_e'(set_bus_i.data[0]);
         end else if (load) begin
            arm_mode <= TIME_SET_NOW;   // One load per arm
         end
      end
   end

   // Time as it stood in the detection cycle
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_pps_o <= '0;
      end else if (pps_edge) begin
         time_pps_o <= time_o;
      end
   end

endmodule

//--- design/misc_ctrl_regs.sv
/* Settings register bank for the board control lines
   Clock gen, SERDES, ADC, PHY reset, plus the hardware/software LED mix */

`timescale 1ns/100ps
`include "u2_core_config.svh"

module misc_ctrl_regs import u2_core_pkg::*; (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  set_bus_t   set_bus_i,
   input  logic       run_tx_i,
   input  logic       run_rx0_i,
   input  logic       run_rx1_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   output misc_ctrl_t ctrl_o,
   output logic [7:0] leds_o
);

   localparam logic [7:0] ADDR_CLK     = 8'(`U2_SR_MISC + MISC_CLK);
   localparam logic [7:0] ADDR_SER     = 8'(`U2_SR_MISC + MISC_SER);
   localparam logic [7:0] ADDR_ADC     = 8'(`U2_SR_MISC + MISC_ADC);
   localparam logic [7:0] ADDR_LED_SW  = 8'(`U2_SR_MISC + MISC_LED_SW);
   localparam logic [7:0] ADDR_PHY     = 8'(`U2_SR_MISC + MISC_PHY);
   localparam logic [7:0] ADDR_LED_SRC = 8'(`U2_SR_MISC + MISC_LED_SRC);

   logic [4:0] clk_reg;       // clock_ready, clk_en, clk_sel
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic       phy_reg;       // 1 holds the PHY in reset
   logic [7:0] led_sw_reg;
   logic [7:0] led_src_reg;   // 1 = hardware, 0 = software
   logic       run_rx_q;
   logic [7:0] led_hw;

   //////////////////////////////
   // Register writes
   //////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clk_reg     <= '0;
         ser_reg     <= '0;
         adc_reg     <= '0;
         phy_reg     <= 1'b0;
         led_sw_reg  <= '0;
         led_src_reg <= `U2_LED_SRC_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            ADDR_CLK:     clk_reg     <= set_bus_i.data[4:0];
            ADDR_SER:     ser_reg     <= set_bus_i.data[3:0];
            ADDR_ADC:     adc_reg     <= set_bus_i.data[3:0];
            ADDR_LED_SW:  led_sw_reg  <= set_bus_i.data[7:0];
            ADDR_PHY:     phy_reg     <= set_bus_i.data[0];
            ADDR_LED_SRC: led_src_reg <= set_bus_i.data[7:0];
            default: begin
            end
         endcase
      end
   end

   // Either receive chain running lights the RX LED
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_rx_q <= 1'b0;
      end else begin
         run_rx_q <= run_rx0_i | run_rx1_i;
      end
   end

   //////////////////////////////
   // Control lines
   //////////////////////////////

   assign ctrl_o.clock_ready = clk_reg[4];
   assign ctrl_o.clk_en      = clk_reg[3:2];
   assign ctrl_o.clk_sel     = clk_reg[1:0];

   assign {ctrl_o.ser_enable, ctrl_o.ser_prbsen,
           ctrl_o.ser_loopen, ctrl_o.ser_rx_en} = ser_reg;

   assign {ctrl_o.adc_oe_a, ctrl_o.adc_on_a,
           ctrl_o.adc_oe_b, ctrl_o.adc_on_b} = adc_reg;

   assign ctrl_o.phy_resetn = ~phy_reg;   // PHY reset pin is active low

   //////////////////////////////
   // LEDs
   //////////////////////////////

   // Bit 0 has no hardware source
   assign led_hw = {3'b000, run_tx_i, run_rx_q, clk_status_i, serdes_link_up_i, 1'b0};

   assign leds_o = (led_src_reg & led_hw) | (~led_src_reg & led_sw_reg);

endmodule

//--- design/u2_core_pkg.sv
/* Types shared by the control slice
   Settings write, board control lines, VITA time and register enums */

package u2_core_pkg;

   // One settings bus write, data valid with stb
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Board control outputs
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_resetn;
   } misc_ctrl_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   typedef enum logic {TIME_SET_NOW = 1'b0, TIME_SET_AT_PPS = 1'b1} time_set_mode_e;

   // Offsets from the misc base
   typedef enum logic [3:0] {
      MISC_CLK     = 4'd0,
      MISC_SER     = 4'd1,
      MISC_ADC     = 4'd2,
      MISC_LED_SW  = 4'd3,
      MISC_PHY     = 4'd4,
      MISC_LED_SRC = 4'd8
   } misc_reg_e;

   // Offsets from the time base
   typedef enum logic [1:0] {TIME_SECS = 2'd0, TIME_TICKS = 2'd1, TIME_IMM = 2'd2} time_reg_e;

   typedef enum logic [3:0] {
      RB_STATUS  = 4'd8,
      RB_SIM     = 4'd9,
      RB_TIME_HI = 4'd10,
      RB_TIME_LO = 4'd11,
      RB_COMPAT  = 4'd12,
      RB_IRQ     = 4'd13,
      RB_PPS_HI  = 4'd14,
      RB_PPS_LO  = 4'd15
   } rb_word_e;

endpackage

//--- include/u2_core_config.svh
/* Shared build constants for the radio core control slice
   Settings bus base addresses, reset values and timing defaults */

`ifndef U2_CORE_CONFIG_SVH
`define U2_CORE_CONFIG_SVH

//////////////////////////////
// Settings bus bases
//////////////////////////////

`define U2_SR_MISC          0     // Board control and LED registers, 9 slots
`define U2_SR_TIME64        192   // VITA time set registers, 3 slots

//////////////////////////////
// Reset values
//////////////////////////////

// Hardware drives LED bits 4:1 out of reset
`define U2_LED_SRC_RESET    8'h1E

//////////////////////////////
// Readback
//////////////////////////////

`define U2_COMPAT_NUM       5     // Bump when the FPGA image changes enough
`define U2_RB_WORDS         16

// Default dsp_clk rate in ticks per second
`define U2_TICKS_PER_SEC    100000000

`endif
